// File: include/mazeLayout.svh
`ifndef MAZE_LAYOUT_SVH
`define MAZE_LAYOUT_SVH

// Wall map of the maze, one entry per row, column 0 in bit 0
// Column 28 is the leftmost digit of each row
localparam logic [gridCols-1:0] mazeWalls [gridRows] = '{
    29'b1_1111_1111_1111_1111_1111_1111_1111,
    // Exit opening in the right border
    29'b0_0000_0000_0100_0000_0100_0100_0001,
    29'b1_1111_0111_0101_1101_0101_1101_0101,
    29'b1_0000_0101_0101_0101_0001_0001_0101,
    29'b1_0111_1101_0101_0101_0111_0111_0101,
    29'b1_0000_0100_0100_0101_0100_0001_0101,
    29'b1_0111_0101_1111_0101_1101_1111_0101,
    29'b1_0001_0100_0100_0100_0101_0000_0101,
    29'b1_1101_0111_1101_1111_0101_0111_1101,
    29'b1_0001_0000_0101_0001_0001_0001_0001,
    29'b1_0101_1111_0101_0101_1101_1101_1101,
    29'b1_0100_0100_0101_0100_0100_0100_0101,
    29'b1_0101_0101_1101_0111_0111_0111_0101,
    29'b1_0101_0100_0001_0100_0100_0001_0101,
    29'b1_0101_0111_1111_0101_1111_1111_0101,
    29'b1_0101_0001_0000_0101_0001_0001_0101,
    29'b1_0101_1101_0111_1101_0101_0101_0101,
    29'b1_0001_0101_0001_0100_0101_0100_0101,
    29'b1_1101_0101_1101_0111_1101_0111_1111,
    29'b1_0101_0101_0001_0000_0101_0000_0001,
    29'b1_0101_0111_0111_0101_1101_0111_1101,
    29'b1_0001_0100_0100_0101_0001_0100_0101,
    29'b1_0111_0101_1101_1111_0111_0101_1101,
    29'b1_0000_0001_0000_0001_0100_0001_0001,
    29'b1_1101_1111_1111_1101_0111_1111_0101,
    29'b1_0101_0000_0000_0001_0100_0001_0101,
    29'b1_0101_1101_1111_1101_0101_1101_0101,
    // Start row, player begins in column 1
    29'b1_0000_0001_0000_0001_0001_0000_0101,
    29'b1_1111_1111_1111_1111_1111_1111_1111
};

`endif

// File: design/mazePkg.sv
package mazePkg;

    // ------------------------------------------------------------------------
    // Maze grid
    // ------------------------------------------------------------------------
    localparam int gridRows = 29;
    localparam int gridCols = 29;

    typedef logic [4:0] tileCoord;

    typedef struct packed {
        tileCoord row;
        tileCoord col;
    } playerPos;

    localparam playerPos startPos = '{row: 5'd27, col: 5'd1};
    localparam playerPos exitPos = '{row: 5'd1, col: 5'd28};

    // ------------------------------------------------------------------------
    // VGA timing, 640x480 inside an 800x521 frame
    // ------------------------------------------------------------------------
    typedef logic [9:0] pixelCount;

    localparam int hPixels = 800;
    localparam int vLines = 521;
    localparam int hPulse = 96;
    localparam int vPulse = 2;
    localparam int hBackPorchEnd = 144;
    localparam int hFrontPorchStart = 784;
    localparam int vBackPorchEnd = 31;
    localparam int vFrontPorchStart = 511;

    // Tile size in pixels, the remainder of the active area stays black
    localparam int tileWidth = (hFrontPorchStart - hBackPorchEnd) / gridCols;
    localparam int tileHeight = (vFrontPorchStart - vBackPorchEnd) / gridRows;

    typedef logic [2:0] colorChannel;

    typedef struct packed {
        colorChannel red;
        colorChannel green;
        colorChannel blue;
    } rgbColor;

    typedef enum logic [1:0] {tileFloor, tileWall, tilePlayer, tileExit} tileKind;

    `include "mazeLayout.svh"

endpackage

// File: design/pixelTiming.sv
`timescale 1ns/1ps

module pixelTiming import mazePkg::*; #(
    parameter int PIXEL_DIV = 4
) (
    input  logic      clk,
    input  logic      btnR,
    output logic      pixelTick,
    output pixelCount hCount,
    output pixelCount vCount,
    output logic      hSyncRaw,
    output logic      vSyncRaw
);

    localparam int divWidth = (PIXEL_DIV > 1) ? $clog2(PIXEL_DIV) : 1;

    logic [divWidth-1:0] divCount;

    // ------------------------------------------------------------------------
    // Pixel clock enable
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge btnR) begin
        if (btnR) begin
            divCount <= '0;
        end else if (pixelTick) begin
            divCount <= '0;
        end else begin
            divCount <= divCount + 1'b1;
        end
    end

    assign pixelTick = (divCount == PIXEL_DIV - 1);

    // ------------------------------------------------------------------------
    // Screen position
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge btnR) begin
        if (btnR) begin
            hCount <= '0;
            vCount <= '0;
        end else if (pixelTick) begin
            if (hCount == hPixels - 1) begin
                hCount <= '0;
                // End of line, so move down or wrap to the top of the frame
                if (vCount == vLines - 1) begin
                    vCount <= '0;
                end else begin
                    vCount <= vCount + 1'b1;
                end
            end else begin
                hCount <= hCount + 1'b1;
            end
        end
    end

    // Active low pulses at the start of each line and frame
    assign hSyncRaw = (hCount >= hPulse);
    assign vSyncRaw = (vCount >= vPulse);

endmodule

// File: design/tileMapper.sv
`timescale 1ns/1ps

module tileMapper import mazePkg::*; (
    input  logic      clk,
    input  logic      btnR,
    input  logic      pixelTick,
    input  pixelCount hCount,
    input  pixelCount vCount,
    output tileCoord  tileRow,
    output tileCoord  tileCol,
    output logic      inTile
);

    localparam int hTileEnd = hBackPorchEnd + gridCols * tileWidth;
    localparam int vTileEnd = vBackPorchEnd + gridRows * tileHeight;

    logic [$clog2(tileWidth)-1:0]  subCol;
    logic [$clog2(tileHeight)-1:0] subRow;
    logic                          hInBand;
    logic                          vInBand;
    logic                          lineEnd;

    assign hInBand = (hCount >= hBackPorchEnd) && (hCount < hTileEnd);
    assign vInBand = (vCount >= vBackPorchEnd) && (vCount < vTileEnd);
    assign inTile = hInBand && vInBand;
    assign lineEnd = pixelTick && (hCount == hPixels - 1);

    // Column tracks the pixel the counter moves to on this tick
    always_ff @(posedge clk or posedge btnR) begin
        if (btnR) begin
            subCol <= '0;
            tileCol <= '0;
        end else if (pixelTick) begin
            if (hCount == hBackPorchEnd - 1) begin
                subCol <= '0;
                tileCol <= '0;
            end else if (hInBand) begin
                if (subCol == tileWidth - 1) begin
                    subCol <= '0;
                    tileCol <= tileCol + 1'b1;
                end else begin
                    subCol <= subCol + 1'b1;
                end
            end
        end
    end

    // Row steps once per line
    always_ff @(posedge clk or posedge btnR) begin
        if (btnR) begin
            subRow <= '0;
            tileRow <= '0;
        end else if (lineEnd) begin
            if (vCount == vBackPorchEnd - 1) begin
                subRow <= '0;
                tileRow <= '0;
            end else if (vInBand) begin
                if (subRow == tileHeight - 1) begin
                    subRow <= '0;
                    tileRow <= tileRow + 1'b1;
                end else begin
                    subRow <= subRow + 1'b1;
                end
            end
        end
    end

endmodule

// File: design/playerControl.sv
`timescale 1ns/1ps

module playerControl import mazePkg::*; #(
    parameter int STEP_CYCLES = 100_000_000
) (
    input  logic     clk,
    input  logic     btnR,
    input  logic     moveLeft,
    input  logic     moveRight,
    input  logic     moveUp,
    input  logic     moveDown,
    output playerPos position,
    output logic     won
);

    localparam int stepWidth = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;

    logic [stepWidth-1:0] stepCount;
    logic                 stepStrobe;
    playerPos             target;
    logic                 targetOpen;

    // ------------------------------------------------------------------------
    // Step rate
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge btnR) begin
        if (btnR) begin
            stepCount <= '0;
        end else if (stepStrobe) begin
            stepCount <= '0;
        end else begin
            stepCount <= stepCount + 1'b1;
        end
    end

    assign stepStrobe = (stepCount == STEP_CYCLES - 1);

    // ------------------------------------------------------------------------
    // Move rules
    // ------------------------------------------------------------------------

    // One direction per step, left wins over right, up and down
    always_comb begin
        target = position;
        if (moveLeft) begin
            target.col = position.col - 1'b1;
        end else if (moveRight) begin
            target.col = position.col + 1'b1;
        end else if (moveUp) begin
            target.row = position.row - 1'b1;
        end else if (moveDown) begin
            target.row = position.row + 1'b1;
        end
    end

    // Stepping off column 0 wraps the index high, caught by the grid bound
    assign targetOpen = (target.row < gridRows) && (target.col < gridCols)
                     && (target.row != 0) && (target.col != 0)
                     && (target.row != gridRows - 1)
                     && !mazeWalls[target.row][target.col];

    always_ff @(posedge clk or posedge btnR) begin
        if (btnR) begin
            position <= startPos;
            won <= 1'b0;
        end else if (stepStrobe && targetOpen) begin
            position <= target;
            // Sticky until the next reset
            if (target == exitPos) begin
                won <= 1'b1;
            end
        end
    end

endmodule

// File: design/pixelRenderer.sv
`timescale 1ns/1ps

module pixelRenderer import mazePkg::*; (
    input  logic     clk,
    input  logic     btnR,
    input  logic     pixelTick,
    input  tileCoord tileRow,
    input  tileCoord tileCol,
    input  logic     inTile,
    input  playerPos position,
    input  logic     won,
    input  logic     hSyncRaw,
    input  logic     vSyncRaw,
    output rgbColor  color,
    output logic     hSync,
    output logic     vSync
);

    localparam rgbColor colorBlack = '{red: 3'b000, green: 3'b000, blue: 3'b000};
    localparam rgbColor colorWhite = '{red: 3'b111, green: 3'b111, blue: 3'b111};
    localparam rgbColor colorMint = '{red: 3'b101, green: 3'b111, blue: 3'b011};
    localparam rgbColor colorYellow = '{red: 3'b111, green: 3'b111, blue: 3'b000};
    localparam rgbColor colorGreen = '{red: 3'b000, green: 3'b111, blue: 3'b000};

    playerPos here;
    tileKind  kind;
    rgbColor  nextColor;

    assign here = '{row: tileRow, col: tileCol};

    // Exit and player are drawn over the wall map
    always_comb begin
        if (here == exitPos) begin
            kind = tileExit;
        end else if (here == position) begin
            kind = tilePlayer;
        end else if (inTile && mazeWalls[tileRow][tileCol]) begin
            kind = tileWall;
        end else begin
            kind = tileFloor;
        end
    end

    always_comb begin
        nextColor = colorBlack;
        if (inTile) begin
            case (kind)
                tileFloor:  nextColor = won ? colorMint : colorWhite;
                tileWall:   nextColor = colorBlack;
                tilePlayer: nextColor = colorYellow;
                tileExit:   nextColor = colorGreen;
            endcase
        end
    end

    // Color and syncs leave on the same tick so they stay aligned
    always_ff @(posedge clk or posedge btnR) begin
        if (btnR) begin
            color <= colorBlack;
            hSync <= 1'b1;
            vSync <= 1'b1;
        end else if (pixelTick) begin
            color <= nextColor;
            hSync <= hSyncRaw;
            vSync <= vSyncRaw;
        end
    end

endmodule

// File: design/mazeTop.sv
`timescale 1ns/1ps

module mazeTop import mazePkg::*; #(
    parameter int PIXEL_DIV = 4,
    parameter int STEP_CYCLES = 100_000_000
) (
    input  logic     clk,
    input  logic     btnR,
    input  logic     moveLeft,
    input  logic     moveRight,
    input  logic     moveUp,
    input  logic     moveDown,
    output logic     hSync,
    output logic     vSync,
    output rgbColor  color,
    output playerPos position,
    output logic     won
);

    logic      pixelTick;
    pixelCount hCount;
    pixelCount vCount;
    logic      hSyncRaw;
    logic      vSyncRaw;
    tileCoord  tileRow;
    tileCoord  tileCol;
    logic      inTile;

    // ------------------------------------------------------------------------
    // Video path
    // ------------------------------------------------------------------------
    pixelTiming #(.PIXEL_DIV(PIXEL_DIV)) timing (
        .clk(clk), .btnR(btnR), .pixelTick(pixelTick),
        .hCount(hCount), .vCount(vCount),
        .hSyncRaw(hSyncRaw), .vSyncRaw(vSyncRaw)
    );

    tileMapper mapper (
        .clk(clk), .btnR(btnR), .pixelTick(pixelTick),
        .hCount(hCount), .vCount(vCount),
        .tileRow(tileRow), .tileCol(tileCol), .inTile(inTile)
    );

    pixelRenderer renderer (
        .clk(clk), .btnR(btnR), .pixelTick(pixelTick),
        .tileRow(tileRow), .tileCol(tileCol), .inTile(inTile),
        .position(position), .won(won),
        .hSyncRaw(hSyncRaw), .vSyncRaw(vSyncRaw),
        .color(color), .hSync(hSync), .vSync(vSync)
    );

    // Game state
    playerControl #(.STEP_CYCLES(STEP_CYCLES)) player (
        .clk(clk), .btnR(btnR),
        .moveLeft(moveLeft), .moveRight(moveRight),
        .moveUp(moveUp), .moveDown(moveDown),
        .position(position), .won(won)
    );

endmodule

// File: sim/mazeTopChecker.sv
`timescale 1ns/1ps

module mazeTopChecker import mazePkg::*; (
    input logic     clk,
    input logic     btnR,
    input logic     hSync,
    input logic     vSync,
    input rgbColor  color,
    input playerPos position,
    input logic     won
);

    int assertFailures = 0;

    // Nothing may be drawn while either sync pulse is active
    blankDuringSync: assert property (@(posedge clk) disable iff (btnR)
        (!hSync || !vSync) |-> (color == '0))
        else begin
            assertFailures++;
            $error("color is not black during a sync pulse");
        end

    // Only the exit cell may sit on the border
    insideBorder: assert property (@(posedge clk) disable iff (btnR)
        (position == exitPos)
        || (position.row != 0 && position.row != gridRows - 1
            && position.col != 0 && position.col != gridCols - 1))
        else begin
            assertFailures++;
            $error("player position lies on the maze border");
        end

    wonHeld: assert property (@(posedge clk) $fell(won) |-> btnR)
        else begin
            assertFailures++;
            $error("won flag dropped without a reset");
        end

endmodule

bind mazeTop mazeTopChecker rules (
    .clk(clk), .btnR(btnR), .hSync(hSync), .vSync(vSync),
    .color(color), .position(position), .won(won)
);

// File: sim/mazeTopTb.sv
`timescale 1ns/1ps

module mazeTopTb import mazePkg::*; ();

    localparam int stepCycles = 16;
    localparam int pixelDiv = 4;

    // One bit per direction input in the order left, right, up, down
    localparam logic [3:0] dirLeft = 4'b1000;
    localparam logic [3:0] dirRight = 4'b0100;
    localparam logic [3:0] dirUp = 4'b0010;
    localparam logic [3:0] dirDown = 4'b0001;
    localparam rgbColor black = '{red: 3'd0, green: 3'd0, blue: 3'd0};

    typedef struct packed {
        logic [3:0] dir;
        playerPos   expected;
    } moveEntry;

    // Walls, border and priority around the start corner
    localparam moveEntry moveTable [12] = '{
        '{dir: dirLeft, expected: '{row: 5'd27, col: 5'd1}},
        '{dir: dirDown, expected: '{row: 5'd27, col: 5'd1}},
        '{dir: dirRight, expected: '{row: 5'd27, col: 5'd1}},
        '{dir: dirUp, expected: '{row: 5'd26, col: 5'd1}},
        '{dir: dirRight, expected: '{row: 5'd26, col: 5'd1}},
        '{dir: dirUp, expected: '{row: 5'd25, col: 5'd1}},
        '{dir: dirUp, expected: '{row: 5'd24, col: 5'd1}},
        '{dir: dirDown, expected: '{row: 5'd25, col: 5'd1}},
        '{dir: dirLeft | dirUp, expected: '{row: 5'd25, col: 5'd1}},
        '{dir: dirRight | dirUp, expected: '{row: 5'd25, col: 5'd1}},
        '{dir: dirUp, expected: '{row: 5'd24, col: 5'd1}},
        '{dir: 4'b0000, expected: '{row: 5'd24, col: 5'd1}}
    };

    logic     clk = 1'b0;
    logic     btnR;
    logic     moveLeft;
    logic     moveRight;
    logic     moveUp;
    logic     moveDown;
    logic     hSync;
    logic     vSync;
    rgbColor  color;
    playerPos position;
    logic     won;

    playerPos modelPos;
    logic     modelWon;
    int       seed = 32'h9522_54d3;

    mazeTop #(.PIXEL_DIV(pixelDiv), .STEP_CYCLES(stepCycles)) DUT (
        .clk(clk), .btnR(btnR),
        .moveLeft(moveLeft), .moveRight(moveRight), .moveUp(moveUp), .moveDown(moveDown),
        .hSync(hSync), .vSync(vSync), .color(color), .position(position), .won(won)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Reporting and compare tasks
    // ------------------------------------------------------------------------
    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic checkPos(input string name, input playerPos got, input playerPos exp);
        if (got !== exp) begin
            $display("error at %0t: %s is (%0d,%0d), expected (%0d,%0d)",
                     $time, name, got.row, got.col, exp.row, exp.col);
            failRun("player position mismatch");
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
            failRun("flag mismatch");
        end
    endtask

    task automatic checkColor(input string name, input rgbColor got, input rgbColor exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            failRun("color mismatch");
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            failRun("measured cycle count mismatch");
        end
    endtask

    always @(posedge clk) begin
        if (DUT.rules.assertFailures != 0) begin
            failRun("a bound assertion failed");
        end
    end

    // ------------------------------------------------------------------------
    // Reference model of the move rules
    // ------------------------------------------------------------------------
    function automatic playerPos predictStep(input playerPos p, input logic [3:0] dir);
        int       r;
        int       c;
        playerPos next;
        r = p.row;
        c = p.col;
        next = p;
        if (dir[3]) begin
            c = c - 1;
        end else if (dir[2]) begin
            c = c + 1;
        end else if (dir[1]) begin
            r = r - 1;
        end else if (dir[0]) begin
            r = r + 1;
        end
        if (r >= 1 && r < gridRows - 1 && c >= 1 && c < gridCols) begin
            if (!mazeWalls[r][c]) begin
                next.row = r[4:0];
                next.col = c[4:0];
            end
        end
        return next;
    endfunction

    function automatic logic [3:0] turnLeft(input logic [3:0] heading);
        case (heading)
            dirUp:   return dirLeft;
            dirLeft: return dirDown;
            dirDown: return dirRight;
            default: return dirUp;
        endcase
    endfunction

    // Keeping the left hand on the outer wall leads to the exit
    function automatic logic [3:0] pickDirection(input playerPos p, input logic [3:0] heading);
        logic [3:0] tries [4];
        tries[0] = turnLeft(heading);
        tries[1] = heading;
        tries[2] = turnLeft(turnLeft(turnLeft(heading)));
        tries[3] = turnLeft(turnLeft(heading));
        for (int i = 0; i < 4; i++) begin
            if (predictStep(p, tries[i]) != p) begin
                return tries[i];
            end
        end
        return heading;
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic applyReset();
        btnR = 1'b1;
        {moveLeft, moveRight, moveUp, moveDown} = 4'b0000;
        repeat (5) @(negedge clk);
        checkPos("position", position, startPos);
        checkBit("won", won, 1'b0);
        checkBit("hSync", hSync, 1'b1);
        checkBit("vSync", vSync, 1'b1);
        checkColor("color", color, black);
        modelPos = startPos;
        modelWon = 1'b0;
        btnR = 1'b0;
    endtask

    // Direction held for one strobe period and released for the next
    task automatic applyStep(input logic [3:0] dir);
        {moveLeft, moveRight, moveUp, moveDown} = dir;
        repeat (stepCycles) @(negedge clk);
        modelPos = predictStep(modelPos, dir);
        if (modelPos == exitPos) begin
            modelWon = 1'b1;
        end
        checkPos("position", position, modelPos);
        checkBit("won", won, modelWon);
        {moveLeft, moveRight, moveUp, moveDown} = 4'b0000;
        repeat (stepCycles) @(negedge clk);
    endtask

    function automatic logic syncLevel(input bit vertical);
        return vertical ? vSync : hSync;
    endfunction

    task automatic waitSync(input bit vertical, input logic level, input int limit);
        int waited;
        waited = 0;
        while (syncLevel(vertical) !== level) begin
            @(negedge clk);
            waited++;
            if (waited > limit) begin
                failRun("sync output did not reach the expected level in time");
            end
        end
    endtask

    task automatic measureSync(input bit vertical, input logic level, input int limit,
                               output int cycles);
        cycles = 0;
        while (syncLevel(vertical) === level) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                failRun("sync output stuck at one level");
            end
        end
    endtask

    initial begin
        int         lowCycles;
        int         highCycles;
        int         walked;
        int         randomValue;
        logic [3:0] heading;
        btnR = 1'b1;
        {moveLeft, moveRight, moveUp, moveDown} = 4'b0000;
        applyReset();
        fork
            begin
                waitSync(1'b1, 1'b0, 100);
                measureSync(1'b1, 1'b0, 10000, lowCycles);
                checkCount("vSync low cycles", lowCycles, 6400);
                waitSync(1'b0, 1'b1, 4000);
                waitSync(1'b0, 1'b0, 4000);
                measureSync(1'b0, 1'b0, 4000, lowCycles);
                measureSync(1'b0, 1'b1, 4000, highCycles);
                checkCount("hSync low cycles", lowCycles, 384);
                checkCount("hSync period cycles", lowCycles + highCycles, 3200);
            end
            begin
                for (int i = 0; i < 12; i++) begin
                    applyStep(moveTable[i].dir);
                    checkPos("table position", position, moveTable[i].expected);
                end
                heading = dirUp;
                walked = 0;
                while (!modelWon) begin
                    if (walked > 2000) begin
                        failRun("player did not reach the exit");
                    end
                    heading = pickDirection(modelPos, heading);
                    applyStep(heading);
                    walked++;
                end
                for (int i = 0; i < 64; i++) begin
                    randomValue = $random(seed);
                    applyStep(randomValue[3:0]);
                end
            end
        join
        applyReset();
        repeat (stepCycles) @(negedge clk);
        checkPos("position", position, startPos);
        checkBit("won", won, 1'b0);
        if (DUT.rules.assertFailures == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            failRun("a bound assertion failed");
        end
    end

endmodule

// File: build.f
+incdir+include
design/mazePkg.sv
design/pixelTiming.sv
design/tileMapper.sv
design/playerControl.sv
design/pixelRenderer.sv
design/mazeTop.sv
sim/mazeTopChecker.sv
sim/mazeTopTb.sv
